/* common/slideshow_pkg.sv */
// Shared widths, gesture codes and defaults; defaults assume an 800x480 image and a 33 MHz clock
`default_nettype none

package slideshow_pkg;

	// ==============================
	// Data types
	// ==============================

	// Current image index, at most 32 images
	typedef logic [4:0]  img_idx_t;
	// Number of images to load
	typedef logic [7:0]  img_cnt_t;
	// Received pixel count
	typedef logic [31:0] pix_cnt_t;
	// Memory word address
	typedef logic [23:0] addr_t;
	// Touch controller gesture code
	typedef logic [7:0]  gesture_t;

	// ==============================
	// Gesture codes and memory layout
	// ==============================

	// Slide to the left
	localparam gesture_t GESTURE_WEST = 8'h1C;
	// Slide to the right
	localparam gesture_t GESTURE_EAST = 8'h14;

	// 16-bit memory bus, 32-bit pixel
	localparam int unsigned WORDS_PER_PIXEL = 2;

	// ==============================
	// Parameter defaults
	// ==============================

	// 800 x 480 pixels
	localparam int unsigned DEF_PIXELS_PER_IMG = 384000;
	localparam int unsigned DEF_PULSE_DELAY    = 10000000;
	localparam int unsigned DEF_HOLDOFF        = 25000000;
	localparam int unsigned DEF_RESET_HOLD     = 1048576;
	localparam int unsigned DEF_LOAD_TAIL      = 50;

endpackage

`default_nettype wire

/* verilog/reset_sequencer.sv */
// Only iRSTN is asynchronous; both outputs are registered and rise in order, RESET_HOLD apart
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int unsigned RESET_HOLD = slideshow_pkg::DEF_RESET_HOLD
) (
	input  logic CLOCK_33,
	input  logic iRSTN,
	output logic core_rst_n,
	output logic display_rst_n
);

	// Counter spans the full two-stage hold
	localparam int unsigned CNT_W = $clog2(2 * RESET_HOLD + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(2 * RESET_HOLD);

	// Compare against the value before the increment
	localparam logic [CNT_W-1:0] CORE_AT    = CNT_W'(RESET_HOLD - 1);
	localparam logic [CNT_W-1:0] DISPLAY_AT = CNT_W'(2 * RESET_HOLD - 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			hold_cnt      <= '0;
			core_rst_n    <= 1'b0;
			display_rst_n <= 1'b0;
		end else begin
			// Saturate once both stages are out of reset
			if (hold_cnt != CNT_MAX) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			// Core first, so control state is sane before gestures
			core_rst_n    <= (hold_cnt >= CORE_AT);
			// Display side last
			display_rst_n <= (hold_cnt >= DISPLAY_AT);
		end
	end

endmodule

`default_nettype wire

/* gesture/gesture_debounce.sv */
// One step per matching gesture, PULSE_DELAY+1 cycles later; assumes PULSE_DELAY < HOLDOFF
`timescale 1ns/1ps
`default_nettype none

module gesture_debounce #(
	parameter int unsigned           PULSE_DELAY  = slideshow_pkg::DEF_PULSE_DELAY,
	parameter int unsigned           HOLDOFF      = slideshow_pkg::DEF_HOLDOFF,
	parameter slideshow_pkg::gesture_t GESTURE_CODE = slideshow_pkg::GESTURE_WEST
) (
	input  logic                    CLOCK_33,
	input  logic                    display_rst_n,
	input  slideshow_pkg::gesture_t gesture,
	input  logic                    gesture_ready,
	output logic                    step
);

	// Counter spans the whole hold-off window
	localparam int unsigned CNT_W = $clog2(HOLDOFF + 1);
	localparam logic [CNT_W-1:0] STEP_AT = CNT_W'(PULSE_DELAY);
	localparam logic [CNT_W-1:0] IDLE_AT = CNT_W'(HOLDOFF);

	// Window open after a matching swipe
	logic             active;
	logic [CNT_W-1:0] win_cnt;

	// ==============================
	// Debounce window
	// ==============================

	always_ff @(posedge CLOCK_33) begin
		if (!display_rst_n) begin
			active  <= 1'b0;
			win_cnt <= '0;
			step    <= 1'b0;
		end else begin
			// Single-cycle pulse by default
			step <= 1'b0;
			if (!active) begin
				win_cnt <= '0;
				// Only this instance's swipe opens the window
				if (gesture_ready && (gesture == GESTURE_CODE)) begin
					active <= 1'b1;
				end
			end else begin
				win_cnt <= win_cnt + 1'b1;
				// Delay reached once per window
				if (win_cnt == STEP_AT) begin
					step <= 1'b1;
				end
				// Hold-off over, next swipe accepted
				if (win_cnt == IDLE_AT) begin
					active <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* slideshow/image_selector.sv */
// Assumes img_count <= 32 and stable while running; steps are ignored until every image is in
`timescale 1ns/1ps
`default_nettype none

module image_selector #(
	parameter int unsigned PIXELS_PER_IMG = slideshow_pkg::DEF_PIXELS_PER_IMG
) (
	input  logic                    CLOCK_33,
	input  logic                    core_rst_n,
	input  logic                    pixel_strobe,
	input  slideshow_pkg::img_cnt_t img_count,
	input  logic                    step_west,
	input  logic                    step_east,
	output slideshow_pkg::img_idx_t current_img,
	output logic                    all_loaded,
	output logic                    pixel_seen
);

	// ==============================
	// Pixel count
	// ==============================

	slideshow_pkg::pix_cnt_t pix_cnt;
	slideshow_pkg::pix_cnt_t pix_total;
	slideshow_pkg::img_idx_t last_img;

	// Total pixels expected for the whole slideshow
	assign pix_total = slideshow_pkg::pix_cnt_t'(img_count)
		* slideshow_pkg::pix_cnt_t'(PIXELS_PER_IMG);

	// Highest valid index, used for the wrap
	assign last_img = slideshow_pkg::img_idx_t'(img_count - 8'd1);

	// Zero images means nothing to wait for
	assign all_loaded = (img_count != '0) && (pix_cnt == pix_total);
	assign pixel_seen = (pix_cnt != '0);

	always_ff @(posedge CLOCK_33) begin
		if (!core_rst_n) begin
			pix_cnt <= '0;
		end else if (pixel_strobe) begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// ==============================
	// Image selection
	// ==============================

	always_ff @(posedge CLOCK_33) begin
		if (!core_rst_n) begin
			current_img <= '0;
		end else if (all_loaded) begin
			// East wins when both arrive together
			if (step_east) begin
				if (current_img == '0) begin
					current_img <= last_img;
				end else begin
					current_img <= current_img - 1'b1;
				end
			end else if (step_west) begin
				if (current_img == last_img) begin
					current_img <= '0;
				end else begin
					current_img <= current_img + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* slideshow/frame_window.sv */
// Window changes only at end_frame, so a frame never shows two images; read_load is high in reset
`timescale 1ns/1ps
`default_nettype none

module frame_window #(
	parameter int unsigned PIXELS_PER_IMG = slideshow_pkg::DEF_PIXELS_PER_IMG
) (
	input  logic                    CLOCK_33,
	input  logic                    core_rst_n,
	input  slideshow_pkg::img_idx_t current_img,
	input  logic                    end_frame,
	input  logic                    new_frame,
	output slideshow_pkg::addr_t    read_base,
	output slideshow_pkg::addr_t    read_limit,
	output logic                    read_load
);

	// Words taken by one image in memory
	localparam slideshow_pkg::addr_t IMG_SPAN =
		slideshow_pkg::addr_t'(PIXELS_PER_IMG * slideshow_pkg::WORDS_PER_PIXEL);

	// Start of the selected image
	slideshow_pkg::addr_t next_base;

	assign next_base = slideshow_pkg::addr_t'(current_img) * IMG_SPAN;

	// ==============================
	// Read window
	// ==============================

	always_ff @(posedge CLOCK_33) begin
		if (!core_rst_n) begin
			// Image 0 on show out of reset
			read_base  <= '0;
			read_limit <= IMG_SPAN;
		end else if (end_frame) begin
			read_base  <= next_base;
			read_limit <= next_base + IMG_SPAN;
		end
	end

	// ==============================
	// FIFO reload strobe
	// ==============================

	always_ff @(posedge CLOCK_33) begin
		if (!core_rst_n) begin
			// Keep the read FIFO flushed during reset
			read_load <= 1'b1;
		end else begin
			// One cycle behind new_frame
			read_load <= new_frame;
		end
	end

endmodule

`default_nettype wire

/* slideshow/load_monitor.sv */
// Loading stays high until LOAD_TAIL+2 cycles after all_loaded; it does not restart without reset
`timescale 1ns/1ps
`default_nettype none

module load_monitor #(
	parameter int unsigned LOAD_TAIL = slideshow_pkg::DEF_LOAD_TAIL
) (
	input  logic CLOCK_33,
	input  logic core_rst_n,
	input  logic all_loaded,
	input  logic pixel_seen,
	output logic loading
);

	localparam int unsigned TAIL_W = $clog2(LOAD_TAIL + 1);
	localparam logic [TAIL_W-1:0] TAIL_END = TAIL_W'(LOAD_TAIL);

	// Set once the last pixel has arrived
	logic              tail;
	logic [TAIL_W-1:0] tail_cnt;

	// ==============================
	// Loading flag
	// ==============================

	always_ff @(posedge CLOCK_33) begin
		if (!core_rst_n) begin
			loading  <= 1'b0;
			tail     <= 1'b0;
			tail_cnt <= '0;
		end else begin
			// Latch the end of loading
			if (all_loaded) begin
				tail <= 1'b1;
			end else if (pixel_seen && !tail) begin
				// First pixel in, display shows the loading screen
				loading <= 1'b1;
			end

			// Let the last writes settle before showing images
			if (tail) begin
				if (tail_cnt < TAIL_END) begin
					tail_cnt <= tail_cnt + 1'b1;
				end else begin
					loading <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/slideshow_top.sv */
// Single clock CLOCK_33; all strobes are one cycle wide and have no back-pressure
`timescale 1ns/1ps
`default_nettype none

module slideshow_top #(
	parameter int unsigned PIXELS_PER_IMG = slideshow_pkg::DEF_PIXELS_PER_IMG,
	parameter int unsigned PULSE_DELAY    = slideshow_pkg::DEF_PULSE_DELAY,
	parameter int unsigned HOLDOFF        = slideshow_pkg::DEF_HOLDOFF,
	parameter int unsigned RESET_HOLD     = slideshow_pkg::DEF_RESET_HOLD,
	parameter int unsigned LOAD_TAIL      = slideshow_pkg::DEF_LOAD_TAIL
) (
	input  logic                    CLOCK_33,
	input  logic                    iRSTN,
	input  logic                    pixel_strobe,
	input  slideshow_pkg::img_cnt_t img_count,
	input  slideshow_pkg::gesture_t gesture,
	input  logic                    gesture_ready,
	input  logic                    end_frame,
	input  logic                    new_frame,
	output slideshow_pkg::addr_t    read_base,
	output slideshow_pkg::addr_t    read_limit,
	output logic                    read_load,
	output logic                    loading,
	output slideshow_pkg::img_idx_t current_img,
	output logic                    all_loaded
);

	logic core_rst_n;
	logic display_rst_n;
	logic step_west;
	logic step_east;
	logic pixel_seen;

	// ==============================
	// Reset ordering
	// ==============================

	reset_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) reset_sequencer_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.core_rst_n    (core_rst_n),
		.display_rst_n (display_rst_n)
	);

	// ==============================
	// Swipe debounce
	// ==============================

	// Slide left, next image
	gesture_debounce #(
		.PULSE_DELAY  (PULSE_DELAY),
		.HOLDOFF      (HOLDOFF),
		.GESTURE_CODE (slideshow_pkg::GESTURE_WEST)
	) west_debounce_i (
		.CLOCK_33      (CLOCK_33),
		.display_rst_n (display_rst_n),
		.gesture       (gesture),
		.gesture_ready (gesture_ready),
		.step          (step_west)
	);

	// Slide right, previous image
	gesture_debounce #(
		.PULSE_DELAY  (PULSE_DELAY),
		.HOLDOFF      (HOLDOFF),
		.GESTURE_CODE (slideshow_pkg::GESTURE_EAST)
	) east_debounce_i (
		.CLOCK_33      (CLOCK_33),
		.display_rst_n (display_rst_n),
		.gesture       (gesture),
		.gesture_ready (gesture_ready),
		.step          (step_east)
	);

	// ==============================
	// Slideshow control
	// ==============================

	image_selector #(
		.PIXELS_PER_IMG (PIXELS_PER_IMG)
	) image_selector_i (
		.CLOCK_33     (CLOCK_33),
		.core_rst_n   (core_rst_n),
		.pixel_strobe (pixel_strobe),
		.img_count    (img_count),
		.step_west    (step_west),
		.step_east    (step_east),
		.current_img  (current_img),
		.all_loaded   (all_loaded),
		.pixel_seen   (pixel_seen)
	);

	frame_window #(
		.PIXELS_PER_IMG (PIXELS_PER_IMG)
	) frame_window_i (
		.CLOCK_33    (CLOCK_33),
		.core_rst_n  (core_rst_n),
		.current_img (current_img),
		.end_frame   (end_frame),
		.new_frame   (new_frame),
		.read_base   (read_base),
		.read_limit  (read_limit),
		.read_load   (read_load)
	);

	load_monitor #(
		.LOAD_TAIL (LOAD_TAIL)
	) load_monitor_i (
		.CLOCK_33   (CLOCK_33),
		.core_rst_n (core_rst_n),
		.all_loaded (all_loaded),
		.pixel_seen (pixel_seen),
		.loading    (loading)
	);

endmodule

`default_nettype wire

/* test/slideshow_asserts.sv */
// Bound into slideshow_top; all properties are idle while core_rst_n is low
`timescale 1ns/1ps
`default_nettype none

module slideshow_asserts (
	input logic                    CLOCK_33,
	input logic                    core_rst_n,
	input logic                    step_west,
	input logic                    step_east,
	input logic                    new_frame,
	input logic                    read_load,
	input logic                    all_loaded,
	input slideshow_pkg::img_idx_t current_img,
	input slideshow_pkg::img_cnt_t img_count
);

	// Two debouncers never fire in the same cycle
	steps_exclusive: assert property (@(posedge CLOCK_33) disable iff (!core_rst_n)
		!(step_west && step_east))
		else $error("west and east step pulses were high together");

	// Reload strobe trails the frame start by one cycle
	reload_follows_frame: assert property (@(posedge CLOCK_33) disable iff (!core_rst_n)
		new_frame |=> read_load)
		else $error("read_load did not follow new_frame by one cycle");

	// Index inside the loaded set
	img_in_range: assert property (@(posedge CLOCK_33) disable iff (!core_rst_n)
		all_loaded |-> ({3'b000, current_img} < img_count))
		else $error("current_img is not below img_count while all images are loaded");

endmodule

bind slideshow_top slideshow_asserts asserts_i (
	.CLOCK_33    (CLOCK_33),
	.core_rst_n  (core_rst_n),
	.step_west   (step_west),
	.step_east   (step_east),
	.new_frame   (new_frame),
	.read_load   (read_load),
	.all_loaded  (all_loaded),
	.current_img (current_img),
	.img_count   (img_count)
);

`default_nettype wire

/* test/slideshow_tb.sv */
// Small parameters for short runs; each gesture row assumes the DUT settles within HOLDOFF+2 cycles
`timescale 1ns/1ps
`default_nettype none

module slideshow_tb;

	localparam int PIXELS_PER_IMG = 8;
	localparam int PULSE_DELAY    = 3;
	localparam int HOLDOFF        = 10;
	localparam int RESET_HOLD     = 4;
	localparam int LOAD_TAIL      = 5;
	// Words per image in memory
	localparam int IMG_SPAN       = PIXELS_PER_IMG * 2;

	typedef enum int {ACT_PIXELS, ACT_EAST, ACT_WEST, ACT_FRAME, ACT_CHECK_LOADING} action_e;

	logic                    CLOCK_33;
	logic                    iRSTN;
	logic                    pixel_strobe;
	slideshow_pkg::img_cnt_t img_count;
	slideshow_pkg::gesture_t gesture;
	logic                    gesture_ready;
	logic                    end_frame;
	logic                    new_frame;
	slideshow_pkg::addr_t    read_base;
	slideshow_pkg::addr_t    read_limit;
	logic                    read_load;
	logic                    loading;
	slideshow_pkg::img_idx_t current_img;
	logic                    all_loaded;

	// Stimulus table columns
	string   row_name[$];
	action_e row_act[$];
	int      row_arg[$];
	int      row_exp[$];

	int error_count;
	int check_count;
	int cycle_count;
	int timeout_limit;
	int total_pixels;

	slideshow_top #(
		.PIXELS_PER_IMG (PIXELS_PER_IMG),
		.PULSE_DELAY    (PULSE_DELAY),
		.HOLDOFF        (HOLDOFF),
		.RESET_HOLD     (RESET_HOLD),
		.LOAD_TAIL      (LOAD_TAIL)
	) dut_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.pixel_strobe  (pixel_strobe),
		.img_count     (img_count),
		.gesture       (gesture),
		.gesture_ready (gesture_ready),
		.end_frame     (end_frame),
		.new_frame     (new_frame),
		.read_base     (read_base),
		.read_limit    (read_limit),
		.read_load     (read_load),
		.loading       (loading),
		.current_img   (current_img),
		.all_loaded    (all_loaded)
	);

	// ==============================
	// Clock and watchdog
	// ==============================

	always #20 CLOCK_33 = ~CLOCK_33;

	always @(posedge CLOCK_33) begin
		cycle_count = cycle_count + 1;
		if (timeout_limit > 0 && cycle_count > timeout_limit) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("checks %0d errors %0d timeouts 1", check_count, error_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ==============================
	// Helpers
	// ==============================

	// Gesture code in bits 7:0, number of sends in bits 11:8
	function automatic int gesture_arg(input int code, input int sends);
		return code | (sends << 8);
	endfunction

	task automatic add_row(input string name, input action_e act, input int arg, input int exp);
		row_name.push_back(name);
		row_act.push_back(act);
		row_arg.push_back(arg);
		row_exp.push_back(exp);
	endtask

	// Leaves the caller 1 ns past a rising edge
	task automatic tick;
		@(posedge CLOCK_33);
		#1;
	endtask

	task automatic check_value(input string name, input int exp, input int got);
		check_count = check_count + 1;
		assert (got == exp) else begin
			$display("mismatch %s expected %0d actual %0d", name, exp, got);
			error_count = error_count + 1;
		end
	endtask

	task automatic send_pixels(input int count);
		int gap;
		for (int p = 0; p < count; p++) begin
			// Random idle gap, 0 to 3 cycles
			gap = int'($urandom % 4);
			repeat (gap) tick();
			pixel_strobe = 1'b1;
			tick();
			pixel_strobe = 1'b0;
		end
	endtask

	task automatic send_gesture(input int arg);
		int sends;
		sends = (arg >> 8) & 15;
		for (int k = 0; k < sends; k++) begin
			// Repeat lands inside the hold-off window
			if (k > 0) begin
				repeat (2) tick();
			end
			gesture       = arg[7:0];
			gesture_ready = 1'b1;
			tick();
			gesture_ready = 1'b0;
		end
		repeat (HOLDOFF + 2) tick();
	endtask

	task automatic pulse_frame(input string name, input int exp_base);
		end_frame = 1'b1;
		tick();
		end_frame = 1'b0;
		check_value({name, " base"}, exp_base, int'(read_base));
		check_value({name, " limit"}, exp_base + IMG_SPAN, int'(read_limit));
		new_frame = 1'b1;
		tick();
		new_frame = 1'b0;
		check_value({name, " load high"}, 1, int'(read_load));
		tick();
		check_value({name, " load low"}, 0, int'(read_load));
	endtask

	task automatic apply_row(input int i);
		case (row_act[i])
			ACT_PIXELS: begin
				send_pixels(row_arg[i]);
				check_value(row_name[i], row_exp[i], int'(all_loaded));
			end
			ACT_EAST, ACT_WEST: begin
				send_gesture(row_arg[i]);
				check_value(row_name[i], row_exp[i], int'(current_img));
			end
			ACT_FRAME: pulse_frame(row_name[i], row_exp[i]);
			ACT_CHECK_LOADING: begin
				repeat (row_arg[i]) tick();
				check_value(row_name[i], row_exp[i], int'(loading));
			end
			default: begin
				$display("row %0d has an unknown action", i);
				error_count = error_count + 1;
			end
		endcase
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(70439));
		CLOCK_33      = 1'b0;
		iRSTN         = 1'b0;
		pixel_strobe  = 1'b0;
		img_count     = 8'd3;
		gesture       = '0;
		gesture_ready = 1'b0;
		end_frame     = 1'b0;
		new_frame     = 1'b0;
		error_count   = 0;
		check_count   = 0;
		cycle_count   = 0;
		timeout_limit = 0;
		total_pixels  = 0;

		// Three images of 8 pixels, 24 strobes in all
		add_row("load_first", ACT_PIXELS, 1, 0);
		add_row("loading_on", ACT_CHECK_LOADING, 1, 1);
		add_row("early_swipe", ACT_EAST, gesture_arg(8'h14, 1), 0);
		add_row("load_rest", ACT_PIXELS, 23, 1);
		add_row("loading_tail", ACT_CHECK_LOADING, LOAD_TAIL + 1, 1);
		add_row("loading_off", ACT_CHECK_LOADING, 1, 0);
		add_row("east_wrap", ACT_EAST, gesture_arg(8'h14, 1), 2);
		add_row("west_wrap", ACT_WEST, gesture_arg(8'h1C, 1), 0);
		add_row("west_holdoff", ACT_WEST, gesture_arg(8'h1C, 2), 1);
		// Image 1 starts at 8 pixels x 2 words
		add_row("frame_img1", ACT_FRAME, 0, 16);
		add_row("odd_code", ACT_WEST, gesture_arg(8'h55, 1), 1);
		add_row("east_back", ACT_EAST, gesture_arg(8'h14, 1), 0);
		add_row("frame_img0", ACT_FRAME, 0, 0);

		for (int i = 0; i < row_name.size(); i++) begin
			if (row_act[i] == ACT_PIXELS) begin
				total_pixels = total_pixels + row_arg[i];
			end
		end
		timeout_limit = row_name.size() * (HOLDOFF + LOAD_TAIL + 10) + total_pixels * 4
			+ 2 * RESET_HOLD + 4;

		// Reset held for two cycles, then wait out the sequencer
		repeat (2) tick();
		iRSTN = 1'b1;
		repeat (2 * RESET_HOLD + 1) tick();

		check_value("reset img", 0, int'(current_img));
		check_value("reset base", 0, int'(read_base));
		check_value("reset limit", IMG_SPAN, int'(read_limit));
		check_value("reset loading", 0, int'(loading));
		check_value("reset all_loaded", 0, int'(all_loaded));
		check_value("reset read_load", 0, int'(read_load));

		for (int i = 0; i < row_name.size(); i++) begin
			apply_row(i);
		end

		$display("checks %0d errors %0d timeouts 0", check_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* slideshow.f */
common/slideshow_pkg.sv
verilog/reset_sequencer.sv
gesture/gesture_debounce.sv
slideshow/image_selector.sv
slideshow/frame_window.sv
slideshow/load_monitor.sv
verilog/slideshow_top.sv
test/slideshow_asserts.sv
test/slideshow_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the slideshow testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module slideshow_tb -f slideshow.f -o slideshow_sim

./obj_dir/slideshow_sim | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	exit 0
fi
exit 1
